// ==== logic/int_exec_defs.svh ====
`ifndef INT_EXEC_DEFS_SVH
`define INT_EXEC_DEFS_SVH

// Datapath and tag sizing for the integer execute path.

`define XLEN      32 // Data word width.
`define PHY_REGS  32 // Physical registers.
`define ROB_DEPTH 16 // ROB entries.
`define ARCH_REGS 32 // Architectural registers.

`endif

// ==== logic/int_exec_pkg.sv ====
`include "int_exec_defs.svh"

package int_exec_pkg;

    typedef logic [`XLEN-1:0]               word_t;     // Data word.
    typedef logic [$clog2(`PHY_REGS)-1:0]   phy_reg_t;  // Physical register index.
    typedef logic [$clog2(`ROB_DEPTH)-1:0]  rob_id_t;   // ROB index.
    typedef logic [$clog2(`ARCH_REGS)-1:0]  arch_reg_t; // Architectural register index.

    // RV32I register-register and immediate ALU operations.
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_xor,
        alu_or,
        alu_and,
        alu_slt,
        alu_sltu
    } alu_op_t;

    typedef enum logic {
        op1_rs1,
        op1_zero
    } op1_sel_t;

    typedef enum logic [1:0] {
        op2_rs2,
        op2_zero,
        op2_imm
    } op2_sel_t;

endpackage

// ==== logic/phys_regfile.sv ====
`timescale 1ns/1ns
`include "int_exec_defs.svh"

module phys_regfile (
    input  logic                  clk,
    input  logic                  rst,
    input  int_exec_pkg::phy_reg_t rs1_phy,
    input  int_exec_pkg::phy_reg_t rs2_phy,
    input  logic                  wr_en,
    input  int_exec_pkg::phy_reg_t wr_phy,
    input  int_exec_pkg::word_t    wr_value,
    output int_exec_pkg::word_t    rs1_value,
    output int_exec_pkg::word_t    rs2_value
);

    import int_exec_pkg::*;

    word_t regs [`PHY_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            regs <= '{default: '0};
        end else if (wr_en && (wr_phy != '0)) begin
            regs[wr_phy] <= wr_value;
        end
    end

    // Write-first read, so a consumer issued in the broadcast cycle sees the result.
    always_comb begin
        if (rs1_phy == '0) begin
            rs1_value = '0;
        end else if (wr_en && (wr_phy == rs1_phy)) begin
            rs1_value = wr_value; // Bypass.
        end else begin
            rs1_value = regs[rs1_phy];
        end
    end

    always_comb begin
        if (rs2_phy == '0) begin
            rs2_value = '0;
        end else if (wr_en && (wr_phy == rs2_phy)) begin
            rs2_value = wr_value; // Bypass.
        end else begin
            rs2_value = regs[rs2_phy];
        end
    end

    // The top filters CDB results aimed at p0 before they reach this port.
    a_no_write_p0: assert property (
        @(posedge clk) disable iff (rst)
        wr_en |-> (wr_phy != '0)
    ) else $error("regfile write to physical register 0");

endmodule

// ==== logic/operand_read.sv ====
`timescale 1ns/1ns
`include "int_exec_defs.svh"

module operand_read (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    issue_valid,
    input  int_exec_pkg::alu_op_t   issue_op,
    input  int_exec_pkg::op1_sel_t  issue_op1_sel,
    input  int_exec_pkg::op2_sel_t  issue_op2_sel,
    input  int_exec_pkg::phy_reg_t  issue_rs1_phy,
    input  int_exec_pkg::phy_reg_t  issue_rs2_phy,
    input  int_exec_pkg::word_t     issue_imm,
    input  int_exec_pkg::rob_id_t   issue_rob_id,
    input  int_exec_pkg::arch_reg_t issue_rd_arch,
    input  int_exec_pkg::phy_reg_t  issue_rd_phy,
    input  int_exec_pkg::word_t     rs1_value,
    input  int_exec_pkg::word_t     rs2_value,
    output int_exec_pkg::phy_reg_t  rs1_phy,
    output int_exec_pkg::phy_reg_t  rs2_phy,
    output logic                    ex_valid,
    output int_exec_pkg::alu_op_t   ex_op,
    output int_exec_pkg::word_t     ex_a,
    output int_exec_pkg::word_t     ex_b,
    output int_exec_pkg::rob_id_t   ex_rob_id,
    output int_exec_pkg::arch_reg_t ex_rd_arch,
    output int_exec_pkg::phy_reg_t  ex_rd_phy
);

    import int_exec_pkg::*;

    word_t a;
    word_t b;

    assign rs1_phy = issue_rs1_phy; // Read addresses go straight out.
    assign rs2_phy = issue_rs2_phy;

    always_comb begin
        unique case (issue_op1_sel)
            op1_rs1:  a = rs1_value;
            op1_zero: a = {`XLEN{1'b0}};
            default:  a = {`XLEN{1'b0}};
        endcase

        unique case (issue_op2_sel)
            op2_rs2:  b = rs2_value;
            op2_zero: b = {`XLEN{1'b0}};
            op2_imm:  b = issue_imm;
            default:  b = {`XLEN{1'b0}};
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_op      <= alu_add;
            ex_a       <= '0;
            ex_b       <= '0;
            ex_rob_id  <= '0;
            ex_rd_arch <= '0;
            ex_rd_phy  <= '0;
        end else if (issue_valid) begin
            ex_op      <= issue_op;
            ex_a       <= a;
            ex_b       <= b;
            ex_rob_id  <= issue_rob_id;
            ex_rd_arch <= issue_rd_arch;
            ex_rd_phy  <= issue_rd_phy;
        end
    end

    a_legal_sel: assert property (
        @(posedge clk) disable iff (rst)
        issue_valid |-> (issue_op1_sel inside {op1_rs1, op1_zero}) &&
                        (issue_op2_sel inside {op2_rs2, op2_zero, op2_imm})
    ) else $error("illegal operand select on issue");

endmodule

// ==== logic/alu_execute.sv ====
`timescale 1ns/1ns
`include "int_exec_defs.svh"

module alu_execute (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    ex_valid,
    input  int_exec_pkg::alu_op_t   ex_op,
    input  int_exec_pkg::word_t     ex_a,
    input  int_exec_pkg::word_t     ex_b,
    input  int_exec_pkg::rob_id_t   ex_rob_id,
    input  int_exec_pkg::arch_reg_t ex_rd_arch,
    input  int_exec_pkg::phy_reg_t  ex_rd_phy,
    output logic                    cdb_valid,
    output int_exec_pkg::rob_id_t   cdb_rob_id,
    output int_exec_pkg::arch_reg_t cdb_rd_arch,
    output int_exec_pkg::phy_reg_t  cdb_rd_phy,
    output int_exec_pkg::word_t     cdb_value
);

    import int_exec_pkg::*;

    logic signed [`XLEN-1:0] as;
    logic signed [`XLEN-1:0] bs;
    logic [4:0]              shamt;
    word_t                   alu_out;

    assign as    = signed'(ex_a);
    assign bs    = signed'(ex_b);
    assign shamt = ex_b[4:0]; // Only the low five bits count.

    always_comb begin
        unique case (ex_op)
            alu_add:  alu_out = ex_a + ex_b;
            alu_sub:  alu_out = ex_a - ex_b;
            alu_sll:  alu_out = ex_a << shamt;
            alu_srl:  alu_out = ex_a >> shamt;
            alu_sra:  alu_out = unsigned'(as >>> shamt); // Sign fill.
            alu_xor:  alu_out = ex_a ^ ex_b;
            alu_or:   alu_out = ex_a | ex_b;
            alu_and:  alu_out = ex_a & ex_b;
            alu_slt:  alu_out = {{(`XLEN-1){1'b0}}, (as < bs)};
            alu_sltu: alu_out = {{(`XLEN-1){1'b0}}, (ex_a < ex_b)};
            default:  alu_out = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= ex_valid;
        end
    end

    // Result and tags hold between broadcasts.
    always_ff @(posedge clk) begin
        if (rst) begin
            cdb_rob_id  <= '0;
            cdb_rd_arch <= '0;
            cdb_rd_phy  <= '0;
            cdb_value   <= '0;
        end else if (ex_valid) begin
            cdb_rob_id  <= ex_rob_id;
            cdb_rd_arch <= ex_rd_arch;
            cdb_rd_phy  <= ex_rd_phy;
            cdb_value   <= alu_out;
        end
    end

    a_legal_op: assert property (
        @(posedge clk) disable iff (rst)
        ex_valid |-> (ex_op inside {alu_add, alu_sub, alu_sll, alu_srl, alu_sra,
                                    alu_xor, alu_or, alu_and, alu_slt, alu_sltu})
    ) else $error("illegal ALU op in execute stage");

endmodule

// ==== logic/int_exec_top.sv ====
`timescale 1ns/1ns
`include "int_exec_defs.svh"

module int_exec_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    issue_valid,
    input  int_exec_pkg::alu_op_t   issue_op,
    input  int_exec_pkg::op1_sel_t  issue_op1_sel,
    input  int_exec_pkg::op2_sel_t  issue_op2_sel,
    input  int_exec_pkg::phy_reg_t  issue_rs1_phy,
    input  int_exec_pkg::phy_reg_t  issue_rs2_phy,
    input  int_exec_pkg::word_t     issue_imm,
    input  int_exec_pkg::rob_id_t   issue_rob_id,
    input  int_exec_pkg::arch_reg_t issue_rd_arch,
    input  int_exec_pkg::phy_reg_t  issue_rd_phy,
    output logic                    cdb_valid,
    output int_exec_pkg::rob_id_t   cdb_rob_id,
    output int_exec_pkg::arch_reg_t cdb_rd_arch,
    output int_exec_pkg::phy_reg_t  cdb_rd_phy,
    output int_exec_pkg::word_t     cdb_value
);

    import int_exec_pkg::*;

    phy_reg_t          rs1_phy;
    phy_reg_t          rs2_phy;
    logic [`XLEN-1:0]  rs1_value;
    logic [`XLEN-1:0]  rs2_value;
    logic              rf_wr_en;

    logic              ex_valid;
    alu_op_t           ex_op;
    logic [`XLEN-1:0]  ex_a;
    logic [`XLEN-1:0]  ex_b;
    rob_id_t           ex_rob_id;
    arch_reg_t         ex_rd_arch;
    phy_reg_t          ex_rd_phy;

    // Results bound for p0 are dropped at the regfile port.
    assign rf_wr_en = cdb_valid && (cdb_rd_phy != '0);

    phys_regfile u_regfile (
        .clk       (clk),
        .rst       (rst),
        .rs1_phy   (rs1_phy),
        .rs2_phy   (rs2_phy),
        .wr_en     (rf_wr_en),
        .wr_phy    (cdb_rd_phy),
        .wr_value  (cdb_value),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value)
    );

    operand_read u_operand_read (
        .clk           (clk),
        .rst           (rst),
        .issue_valid   (issue_valid),
        .issue_op      (issue_op),
        .issue_op1_sel (issue_op1_sel),
        .issue_op2_sel (issue_op2_sel),
        .issue_rs1_phy (issue_rs1_phy),
        .issue_rs2_phy (issue_rs2_phy),
        .issue_imm     (issue_imm),
        .issue_rob_id  (issue_rob_id),
        .issue_rd_arch (issue_rd_arch),
        .issue_rd_phy  (issue_rd_phy),
        .rs1_value     (rs1_value),
        .rs2_value     (rs2_value),
        .rs1_phy       (rs1_phy),
        .rs2_phy       (rs2_phy),
        .ex_valid      (ex_valid),
        .ex_op         (ex_op),
        .ex_a          (ex_a),
        .ex_b          (ex_b),
        .ex_rob_id     (ex_rob_id),
        .ex_rd_arch    (ex_rd_arch),
        .ex_rd_phy     (ex_rd_phy)
    );

    alu_execute u_alu_execute (
        .clk         (clk),
        .rst         (rst),
        .ex_valid    (ex_valid),
        .ex_op       (ex_op),
        .ex_a        (ex_a),
        .ex_b        (ex_b),
        .ex_rob_id   (ex_rob_id),
        .ex_rd_arch  (ex_rd_arch),
        .ex_rd_phy   (ex_rd_phy),
        .cdb_valid   (cdb_valid),
        .cdb_rob_id  (cdb_rob_id),
        .cdb_rd_arch (cdb_rd_arch),
        .cdb_rd_phy  (cdb_rd_phy),
        .cdb_value   (cdb_value)
    );

endmodule

// ==== testbench/int_exec_tb.sv ====
`timescale 1ns/1ns
`include "int_exec_defs.svh"

module int_exec_tb;

    import int_exec_pkg::*;

    localparam int NUM_ROWS        = 30;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * 4 + 50;

    typedef struct packed {
        logic [31:0] value;
        rob_id_t     rob_id;
        arch_reg_t   rd_arch;
        phy_reg_t    rd_phy;
        logic [31:0] cycle; // Negedge count at which the broadcast is due.
        logic [7:0]  row;
    } expect_t;

    logic      clk;
    logic      rst;
    logic      issue_valid;
    alu_op_t   issue_op;
    op1_sel_t  issue_op1_sel;
    op2_sel_t  issue_op2_sel;
    phy_reg_t  issue_rs1_phy;
    phy_reg_t  issue_rs2_phy;
    word_t     issue_imm;
    rob_id_t   issue_rob_id;
    arch_reg_t issue_rd_arch;
    phy_reg_t  issue_rd_phy;
    logic      cdb_valid;
    rob_id_t   cdb_rob_id;
    arch_reg_t cdb_rd_arch;
    phy_reg_t  cdb_rd_phy;
    word_t     cdb_value;

    alu_op_t   t_op   [NUM_ROWS];
    op1_sel_t  t_sel1 [NUM_ROWS];
    op2_sel_t  t_sel2 [NUM_ROWS];
    phy_reg_t  t_rs1  [NUM_ROWS];
    phy_reg_t  t_rs2  [NUM_ROWS];
    word_t     t_imm  [NUM_ROWS];
    phy_reg_t  t_rd   [NUM_ROWS];
    arch_reg_t t_arch [NUM_ROWS];
    int        t_gap  [NUM_ROWS];

    word_t       shadow [`PHY_REGS] = '{default: '0};
    expect_t     pending [$];
    logic [31:0] lcg_state = 32'd52529;
    int          cycle_count = 0;
    int          error_count = 0;
    int          check_count = 0;
    int          test_count  = 0;

    int_exec_top UUT (.*);

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [31:0] alu_model(alu_op_t op, logic [31:0] a, logic [31:0] b);
        logic [4:0]  sh;
        logic [31:0] fill;
        logic [31:0] res;
        sh   = b[4:0];
        fill = a[31] ? ~(32'hFFFF_FFFF >> sh) : 32'd0; // Sign bits shifted in from the top.
        case (op)
            alu_add:  res = a + b;
            alu_sub:  res = a - b;
            alu_sll:  res = a << sh;
            alu_srl:  res = a >> sh;
            alu_sra:  res = (a >> sh) | fill;
            alu_xor:  res = a ^ b;
            alu_or:   res = a | b;
            alu_and:  res = a & b;
            alu_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:  res = (a < b) ? 32'd1 : 32'd0;
        endcase
        return res;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %h, expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic set_row(input int idx, input alu_op_t op, input op1_sel_t s1,
                           input op2_sel_t s2, input phy_reg_t rs1, input phy_reg_t rs2,
                           input word_t imm, input phy_reg_t rd, input int gap);
        t_op[idx]   = op;
        t_sel1[idx] = s1;
        t_sel2[idx] = s2;
        t_rs1[idx]  = rs1;
        t_rs2[idx]  = rs2;
        t_imm[idx]  = imm;
        t_rd[idx]   = rd;
        t_arch[idx] = arch_reg_t'(5'd31 - rd); // Never equal to the physical tag.
        t_gap[idx]  = gap;
    endtask

    task automatic build_table();
        phy_reg_t ra;
        phy_reg_t rb;
        // Immediate loads into p1..p8, issued back to back.
        set_row(0, alu_add, op1_zero, op2_imm, 5'd0, 5'd0, 32'h8000_00F0, 5'd1, 0);
        set_row(1, alu_add, op1_zero, op2_imm, 5'd0, 5'd0, 32'h0000_0025, 5'd2, 0);
        set_row(2, alu_add, op1_zero, op2_imm, 5'd0, 5'd0, 32'h0000_1234, 5'd3, 0);
        for (int k = 3; k < 8; k++) begin
            set_row(k, alu_add, op1_zero, op2_imm, 5'd0, 5'd0, lcg_next(),
                    phy_reg_t'(k + 1), (k == 7) ? 3 : 0);
        end
        for (int k = 0; k < 10; k++) begin
            ra = phy_reg_t'(32'd1 + (lcg_next() >> 16) % 32'd8);
            rb = phy_reg_t'(32'd1 + (lcg_next() >> 16) % 32'd8);
            set_row(8 + k, alu_op_t'(k), op1_rs1, op2_rs2, ra, rb, 32'd0,
                    phy_reg_t'(9 + k), int'((lcg_next() >> 16) % 32'd2));
        end
        set_row(18, alu_sll,  op1_rs1, op2_rs2, 5'd3, 5'd2, 32'd0, 5'd19, 0); // Shift by 37.
        set_row(19, alu_srl,  op1_rs1, op2_rs2, 5'd1, 5'd2, 32'd0, 5'd20, 0);
        set_row(20, alu_sra,  op1_rs1, op2_rs2, 5'd1, 5'd2, 32'd0, 5'd21, 0);
        set_row(21, alu_sra,  op1_rs1, op2_imm, 5'd1, 5'd0, 32'h3F, 5'd22, 0);
        set_row(22, alu_slt,  op1_rs1, op2_rs2, 5'd1, 5'd3, 32'd0, 5'd23, 0);
        set_row(23, alu_sltu, op1_rs1, op2_rs2, 5'd1, 5'd3, 32'd0, 5'd24, 2);
        // Each consumer issues in its producer's broadcast cycle.
        set_row(24, alu_add, op1_rs1, op2_rs2, 5'd1, 5'd3, 32'd0, 5'd25, 1);
        set_row(25, alu_xor, op1_rs1, op2_rs2, 5'd25, 5'd4, 32'd0, 5'd26, 1);
        set_row(26, alu_sub, op1_rs1, op2_rs2, 5'd26, 5'd25, 32'd0, 5'd27, 0);
        set_row(27, alu_add, op1_zero, op2_imm, 5'd0, 5'd0, 32'hDEAD_BEEF, 5'd0, 2);
        set_row(28, alu_or,  op1_rs1, op2_rs2, 5'd0, 5'd0, 32'd0, 5'd28, 0);
        set_row(29, alu_add, op1_rs1, op2_imm, 5'd0, 5'd0, 32'd5, 5'd29, 3);
    endtask

    task automatic predict(input int idx);
        word_t   a;
        word_t   b;
        expect_t e;
        a = (t_sel1[idx] == op1_rs1) ? shadow[t_rs1[idx]] : 32'd0;
        case (t_sel2[idx])
            op2_rs2: b = shadow[t_rs2[idx]];
            op2_imm: b = t_imm[idx];
            default: b = 32'd0;
        endcase
        e.value   = alu_model(t_op[idx], a, b);
        e.rob_id  = rob_id_t'(idx % 16);
        e.rd_arch = t_arch[idx];
        e.rd_phy  = t_rd[idx];
        e.cycle   = 32'(cycle_count + 2); // Sampling edge, then one more edge to the CDB.
        e.row     = 8'(idx);
        pending.push_back(e);
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cycle_count++;

    // Any broadcast without a micro-op in flight is an error, before the first issue too.
    always @(negedge clk) begin
        expect_t e;
        int      errs_before;
        if (cdb_valid === 1'b1) begin
            if (pending.size() == 0) begin
                $display("Broadcast at %0t ns with no micro-op in flight", $time);
                error_count++;
            end else begin
                e = pending.pop_front();
                errs_before = error_count;
                check("broadcast cycle", 32'(cycle_count), e.cycle);
                check("cdb_value", cdb_value, e.value);
                check("cdb_rob_id", 32'(cdb_rob_id), 32'(e.rob_id));
                check("cdb_rd_arch", 32'(cdb_rd_arch), 32'(e.rd_arch));
                check("cdb_rd_phy", 32'(cdb_rd_phy), 32'(e.rd_phy));
                if (e.rd_phy != 5'd0) shadow[e.rd_phy] = e.value;
                test_count++;
                $display("test %0d to p%0d: %s", e.row, e.rd_phy,
                         (error_count == errs_before) ? "pass" : "fail");
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin
        rst           = 1'b1;
        issue_valid   = 1'b0;
        issue_op      = alu_add;
        issue_op1_sel = op1_rs1;
        issue_op2_sel = op2_rs2;
        issue_rs1_phy = 5'd0;
        issue_rs2_phy = 5'd0;
        issue_imm     = 32'd0;
        issue_rob_id  = 4'd0;
        issue_rd_arch = 5'd0;
        issue_rd_phy  = 5'd0;
        build_table();
        repeat (4) @(posedge clk);
        #10;
        rst = 1'b0;
        repeat (3) @(posedge clk); // Idle, cdb_valid must stay low.
        #10;
        for (int i = 0; i < NUM_ROWS; i++) begin
            issue_op      = t_op[i];
            issue_op1_sel = t_sel1[i];
            issue_op2_sel = t_sel2[i];
            issue_rs1_phy = t_rs1[i];
            issue_rs2_phy = t_rs2[i];
            issue_imm     = t_imm[i];
            issue_rob_id  = rob_id_t'(i % 16);
            issue_rd_arch = t_arch[i];
            issue_rd_phy  = t_rd[i];
            issue_valid   = 1'b1;
            @(negedge clk);
            #1;
            predict(i);
            @(posedge clk);
            #10;
            issue_valid = 1'b0;
            repeat (t_gap[i]) begin
                @(posedge clk);
                #10;
            end
        end
        while (pending.size() != 0) @(posedge clk);
        repeat (3) @(posedge clk);
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0 && test_count == NUM_ROWS) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+logic
logic/int_exec_pkg.sv
logic/phys_regfile.sv
logic/operand_read.sv
logic/alu_execute.sv
logic/int_exec_top.sv
testbench/int_exec_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the integer execute path testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f list.f \
    --top-module int_exec_tb \
    -o int_exec_sim

output="$(./obj_dir/int_exec_sim)"
echo "$output"

if grep -q "^Test completed successfully$" <<< "$output"; then
    exit 0
fi
exit 1
